// ==== hw/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Byte buffer geometry
`define SPI_BUF_DEPTH 32
`define SPI_ADDR_W 5

// Data widths
`define SPI_BYTE_W 8
`define SPI_WORD_W 32

// clk_i cycles per SCLK half period
`define SPI_HALF_PERIOD 6

`endif

// ==== hw/spi_pkg.sv ====
`include "spi_defines.svh"

package spi_pkg;

    ////////////////////////////////
    // Control / status word
    ////////////////////////////////

    // Command as written by the host
    typedef struct packed {
        logic [`SPI_WORD_W-`SPI_ADDR_W-5:0] rsvd;
        logic [`SPI_ADDR_W-1:0]             count_m1;   // Bytes minus one
        logic                               fill_zeros;
        logic                               fill_ones;
        logic                               cs_en;
        logic                               send;
    } ctrl_cmd_t;

    // Same word after the transfer
    typedef struct packed {
        logic [`SPI_WORD_W-`SPI_ADDR_W-18:0] rsvd_hi;
        logic [`SPI_ADDR_W:0]                xfer_done;  // Bits 21..16
        logic [11-`SPI_ADDR_W:0]             rsvd_mid;
        logic [`SPI_ADDR_W-1:0]              count_m1;
        logic                                fill_zeros;
        logic                                fill_ones;
        logic                                cs_en;
        logic                                send;      // Cleared on write-back
    } ctrl_stat_t;

    typedef union packed {
        ctrl_cmd_t  cmd;
        ctrl_stat_t stat;
    } ctrl_word_u;

    ////////////////////////////////
    // Sequencer
    ////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        SHIFT,
        STORE,
        NEXT,
        FINISH
    } seq_state_t;

endpackage

// ==== hw/spi_buf_if.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

// One access port into the byte buffer
interface spi_buf_if;

    logic [`SPI_ADDR_W-1:0] addr;
    logic                   re;
    logic                   we;
    logic [`SPI_BYTE_W-1:0] wdata;
    logic [`SPI_BYTE_W-1:0] rdata;
    logic                   rvalid;     // One cycle after re

    modport master (
        output addr, re, we, wdata,
        input  rdata, rvalid
    );

    modport arb (
        input  addr, re, we, wdata,
        output rdata, rvalid
    );

endinterface

// ==== hw/spi_byte_if.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

// Single byte exchange, sequencer to shifter
interface spi_byte_if;

    logic                   start;      // Loads tx_byte
    logic [`SPI_BYTE_W-1:0] tx_byte;
    logic [`SPI_BYTE_W-1:0] rx_byte;    // Valid with done
    logic                   done;

    modport ctrl (
        output start, tx_byte,
        input  rx_byte, done
    );

    modport shift (
        input  start, tx_byte,
        output rx_byte, done
    );

endinterface

// ==== hw/spi_shifter.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_shifter (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        miso_i,
    output logic        sclk_o,
    output logic        mosi_o,
    spi_byte_if.shift   byte_port
);

    localparam int HP_W  = $clog2(`SPI_HALF_PERIOD);
    localparam int BIT_W = $clog2(`SPI_BYTE_W);

    logic [HP_W-1:0]        hp_cnt;
    logic [BIT_W-1:0]       bit_cnt;    // Falling edges so far
    logic                   active;
    logic                   sclk_q;
    logic                   done_q;
    logic                   edge_tick;
    logic [`SPI_BYTE_W-1:0] tx_sreg;
    logic [`SPI_BYTE_W-1:0] rx_sreg;

    assign edge_tick = active && (hp_cnt == HP_W'(`SPI_HALF_PERIOD - 1));

    //////////////////////////////
    // Edge timer and shift regs
    //////////////////////////////

    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            hp_cnt  <= '0;
            bit_cnt <= '0;
            active  <= 1'b0;
            sclk_q  <= 1'b0;
            done_q  <= 1'b0;
            tx_sreg <= '0;
            rx_sreg <= '0;
        end else begin
            done_q <= 1'b0;
            if (byte_port.start) begin
                active  <= 1'b1;
                hp_cnt  <= '0;
                bit_cnt <= '0;
                tx_sreg <= byte_port.tx_byte;   // MSB on MOSI right away
            end else if (active) begin
                if (edge_tick) begin
                    hp_cnt <= '0;
                    sclk_q <= ~sclk_q;
                    if (!sclk_q) begin
                        // Rising edge samples MISO
                        rx_sreg <= {rx_sreg[`SPI_BYTE_W-2:0], miso_i};
                    end else begin
                        tx_sreg <= {tx_sreg[`SPI_BYTE_W-2:0], 1'b0};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(`SPI_BYTE_W - 1)) begin
                            active <= 1'b0;
                            done_q <= 1'b1;
                        end
                    end
                end else begin
                    hp_cnt <= hp_cnt + 1'b1;
                end
            end
        end
    end

    assign sclk_o            = sclk_q;
    assign mosi_o            = tx_sreg[`SPI_BYTE_W-1];  // Zeros shifted in, low when idle
    assign byte_port.rx_byte = rx_sreg;
    assign byte_port.done    = done_q;

    // Sequencer must wait for done before the next byte
    a_no_start_busy: assert property (
        @(posedge clk_i) disable iff (rst_i)
        byte_port.start |-> !active
    );

endmodule

// ==== hw/spi_sequencer.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_sequencer
    import spi_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   ctrl_we_i,
    input  logic [`SPI_WORD_W-1:0] ctrl_wdata_i,
    output ctrl_word_u             ctrl_rdata_o,
    output logic                   cs_n_o,
    output logic                   done_o,
    spi_buf_if.master              buf_port,
    spi_byte_if.ctrl               byte_port
);

    seq_state_t             state;
    ctrl_word_u             ctrl_q;
    ctrl_word_u             cmd_in;
    ctrl_stat_t             stat_w;
    logic [`SPI_ADDR_W-1:0] idx;        // Buffer entry in use
    logic [`SPI_ADDR_W-1:0] remain;     // Bytes left after this one
    logic [`SPI_BYTE_W-1:0] rx_q;
    logic                   started;
    logic                   cs_n_q;
    logic                   done_q;
    logic                   fill_any;
    logic                   launch;

    assign cmd_in   = ctrl_wdata_i;
    assign fill_any = ctrl_q.cmd.fill_ones | ctrl_q.cmd.fill_zeros;

    // Fill byte needs no buffer read, otherwise wait for rvalid
    assign launch = (state == SHIFT) && !started && (fill_any || buf_port.rvalid);

    //////////////////////////////
    // Status view of the word
    //////////////////////////////

    always_comb begin
        stat_w            = '0;
        stat_w.cs_en      = ctrl_q.cmd.cs_en;
        stat_w.fill_ones  = ctrl_q.cmd.fill_ones;
        stat_w.fill_zeros = ctrl_q.cmd.fill_zeros;
        stat_w.count_m1   = ctrl_q.cmd.count_m1;
        stat_w.xfer_done  = {1'b0, idx} + 1'b1;
    end

    //////////////////////////////
    // Transfer FSM
    //////////////////////////////

    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            state   <= IDLE;
            ctrl_q  <= '0;
            idx     <= '0;
            remain  <= '0;
            started <= 1'b0;
            cs_n_q  <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (ctrl_we_i) begin
                        ctrl_q <= cmd_in;
                        if (cmd_in.cmd.send && cmd_in.cmd.cs_en) begin
                            cs_n_q <= 1'b0;
                            idx    <= '0;
                            remain <= cmd_in.cmd.count_m1;
                            state  <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    started <= 1'b0;
                    state   <= SHIFT;
                end
                SHIFT: begin
                    if (launch)
                        started <= 1'b1;
                    if (byte_port.done)
                        state <= STORE;
                end
                STORE: state <= NEXT;
                NEXT: begin
                    if (remain == '0) begin
                        state <= FINISH;
                    end else begin
                        idx    <= idx + 1'b1;
                        remain <= remain - 1'b1;
                        state  <= FETCH;
                    end
                end
                FINISH: begin
                    cs_n_q      <= 1'b1;
                    ctrl_q.stat <= stat_w;
                    done_q      <= 1'b1;
                    state       <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (byte_port.done)
            rx_q <= byte_port.rx_byte;
    end

    // Ones wins over zeros
    always_comb begin
        if (ctrl_q.cmd.fill_ones)
            byte_port.tx_byte = '1;
        else if (ctrl_q.cmd.fill_zeros)
            byte_port.tx_byte = '0;
        else
            byte_port.tx_byte = buf_port.rdata;
    end

    assign byte_port.start = launch;

    assign buf_port.addr  = idx;
    assign buf_port.re    = (state == FETCH) && !fill_any;
    assign buf_port.we    = (state == STORE);     // Received byte back to same entry
    assign buf_port.wdata = rx_q;

    assign ctrl_rdata_o = ctrl_q;
    assign cs_n_o       = cs_n_q;
    assign done_o       = done_q;

    // Host must not write the control word mid transfer
    a_ctrl_we_idle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ctrl_we_i |-> state == IDLE
    );

endmodule

// ==== hw/spi_buf_arbiter.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_buf_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   host_we_i,
    input  logic                   host_re_i,
    input  logic [`SPI_ADDR_W-1:0] host_addr_i,
    input  logic [`SPI_BYTE_W-1:0] host_wdata_i,
    output logic [`SPI_BYTE_W-1:0] host_rdata_o,
    output logic                   host_rvalid_o,
    spi_buf_if.arb                 eng_port
);

    logic [`SPI_BYTE_W-1:0] mem [`SPI_BUF_DEPTH];

    // Holding slot for a host request that lost to the engine
    logic                   hold_valid;
    logic                   hold_we;
    logic                   hold_re;
    logic [`SPI_ADDR_W-1:0] hold_addr;
    logic [`SPI_BYTE_W-1:0] hold_wdata;

    logic                   eng_acc;
    logic                   host_req;
    logic                   svc_we;
    logic                   svc_re;
    logic [`SPI_ADDR_W-1:0] svc_addr;
    logic [`SPI_BYTE_W-1:0] svc_wdata;
    logic [`SPI_BYTE_W-1:0] rd_q;
    logic                   eng_rvalid_q;
    logic                   host_rvalid_q;

    assign eng_acc  = eng_port.re | eng_port.we;
    assign host_req = host_we_i | host_re_i;

    //////////////////////////////
    // Service select
    //////////////////////////////

    // Engine first, then parked host, then new host
    always_comb begin
        if (eng_acc) begin
            svc_we    = eng_port.we;
            svc_re    = eng_port.re;
            svc_addr  = eng_port.addr;
            svc_wdata = eng_port.wdata;
        end else if (hold_valid) begin
            svc_we    = hold_we;
            svc_re    = hold_re;
            svc_addr  = hold_addr;
            svc_wdata = hold_wdata;
        end else begin
            svc_we    = host_we_i;
            svc_re    = host_re_i;
            svc_addr  = host_addr_i;
            svc_wdata = host_wdata_i;
        end
    end

    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            hold_valid    <= 1'b0;
            eng_rvalid_q  <= 1'b0;
            host_rvalid_q <= 1'b0;
        end else begin
            hold_valid    <= host_req && (eng_acc || hold_valid);
            eng_rvalid_q  <= eng_port.re;
            host_rvalid_q <= svc_re && !eng_acc;
        end
    end

    always_ff @(posedge clk_i) begin
        hold_we    <= host_we_i;
        hold_re    <= host_re_i;
        hold_addr  <= host_addr_i;
        hold_wdata <= host_wdata_i;
        if (svc_we)
            mem[svc_addr] <= svc_wdata;
        if (svc_re)
            rd_q <= mem[svc_addr];
    end

    assign eng_port.rdata  = rd_q;      // Shared, valids never overlap
    assign eng_port.rvalid = eng_rvalid_q;
    assign host_rdata_o    = rd_q;
    assign host_rvalid_o   = host_rvalid_q;

    // Engine never hits two cycles in a row so the slot always drains
    a_hold_free: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (host_req && eng_acc) |-> !hold_valid
    );

endmodule

// ==== hw/spi_master_top.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_master_top
    import spi_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   host_we_i,
    input  logic                   host_re_i,
    input  logic [`SPI_ADDR_W-1:0] host_addr_i,
    input  logic [`SPI_BYTE_W-1:0] host_wdata_i,
    output logic [`SPI_BYTE_W-1:0] host_rdata_o,
    output logic                   host_rvalid_o,
    input  logic                   ctrl_we_i,
    input  logic [`SPI_WORD_W-1:0] ctrl_wdata_i,
    output logic [`SPI_WORD_W-1:0] ctrl_rdata_o,
    output logic                   cs_n_o,
    output logic                   sclk_o,
    output logic                   mosi_o,
    input  logic                   miso_i,
    output logic                   done_o
);

    ctrl_word_u ctrl_word;

    spi_buf_if  buf_bus ();
    spi_byte_if byte_bus ();

    spi_sequencer u_seq (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ctrl_we_i    (ctrl_we_i),
        .ctrl_wdata_i (ctrl_wdata_i),
        .ctrl_rdata_o (ctrl_word),
        .cs_n_o       (cs_n_o),
        .done_o       (done_o),
        .buf_port     (buf_bus.master),
        .byte_port    (byte_bus.ctrl)
    );

    spi_shifter u_shift (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .miso_i    (miso_i),
        .sclk_o    (sclk_o),
        .mosi_o    (mosi_o),
        .byte_port (byte_bus.shift)
    );

    spi_buf_arbiter u_arb (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .host_we_i     (host_we_i),
        .host_re_i     (host_re_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .eng_port      (buf_bus.arb)
    );

    assign ctrl_rdata_o = ctrl_word;    // Raw bits to the host

endmodule

// ==== test/tb_spi_master.sv ====
`timescale 1ns/1ps
`include "spi_defines.svh"

module tb_spi_master
    import spi_pkg::*;
();

    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DELAY = 2;
    localparam int          NUM_CMDS    = 40;
    localparam int          BYTE_CYCLES = 120;     // Budget per byte incl. FSM overhead
    localparam int          IDLE_WINDOW = 200;
    localparam int          HALF_NS     = `SPI_HALF_PERIOD * CLK_PERIOD;  // SCLK phase in ns
    localparam logic [31:0] SEED        = 32'he519baf1;

    logic                   clk_i        = 1'b0;
    logic                   rst_i        = 1'b1;
    logic                   host_we_i    = 1'b0;
    logic                   host_re_i    = 1'b0;
    logic [`SPI_ADDR_W-1:0] host_addr_i  = '0;
    logic [`SPI_BYTE_W-1:0] host_wdata_i = '0;
    logic                   ctrl_we_i    = 1'b0;
    logic [`SPI_WORD_W-1:0] ctrl_wdata_i = '0;
    logic                   miso_i       = 1'b0;
    logic [`SPI_BYTE_W-1:0] host_rdata_o;
    logic                   host_rvalid_o;
    logic [`SPI_WORD_W-1:0] ctrl_rdata_o;
    logic                   cs_n_o;
    logic                   sclk_o;
    logic                   mosi_o;
    logic                   done_o;

    logic [`SPI_BYTE_W-1:0] model_mem [`SPI_BUF_DEPTH];    // Expected buffer

    // Slave side record
    logic [`SPI_BYTE_W-1:0] mosi_seen_q [$];
    logic [`SPI_BYTE_W-1:0] miso_sent_q [$];
    logic [`SPI_BYTE_W-1:0] slave_tx;
    logic [`SPI_BYTE_W-1:0] slave_rx;
    int                     slave_bits;
    logic                   cs_prev     = 1'b1;
    logic                   sclk_prev   = 1'b0;
    time                    sclk_edge_t = 0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    spi_master_top dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .host_we_i     (host_we_i),
        .host_re_i     (host_re_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .ctrl_we_i     (ctrl_we_i),
        .ctrl_wdata_i  (ctrl_wdata_i),
        .ctrl_rdata_o  (ctrl_rdata_o),
        .cs_n_o        (cs_n_o),
        .sclk_o        (sclk_o),
        .mosi_o        (mosi_o),
        .miso_i        (miso_i),
        .done_o        (done_o)
    );

    //////////////////////////////
    // SPI slave, mode 0
    //////////////////////////////

    always @(cs_n_o or sclk_o) begin
        if (cs_n_o === 1'b0) begin
            if (cs_prev !== 1'b0) begin
                slave_tx   = 8'($urandom);     // First bit out at CS fall
                slave_bits = 0;
                miso_i     = slave_tx[7];
            end else if (sclk_o === 1'b1 && sclk_prev !== 1'b1) begin
                if (slave_bits != 0)
                    compare_value("sclk_o low time", HALF_NS, 32'($time - sclk_edge_t));
                sclk_edge_t = $time;
                slave_rx    = {slave_rx[6:0], mosi_o};
                slave_bits  = slave_bits + 1;
                if (slave_bits == 8) begin
                    mosi_seen_q.push_back(slave_rx);
                    miso_sent_q.push_back(slave_tx);
                    slave_bits = 0;
                end
            end else if (sclk_o === 1'b0 && sclk_prev === 1'b1) begin
                compare_value("sclk_o high time", HALF_NS, 32'($time - sclk_edge_t));
                sclk_edge_t = $time;
                if (slave_bits == 0)
                    slave_tx = 8'($urandom);
                miso_i = slave_tx[7 - slave_bits];
            end
        end
        cs_prev   = cs_n_o;
        sclk_prev = sclk_o;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp)
            abort_run($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    endtask

    task automatic host_write(input int addr, input logic [`SPI_BYTE_W-1:0] data);
        host_addr_i  = `SPI_ADDR_W'(addr);
        host_wdata_i = data;
        host_we_i    = 1'b1;
        next_cycle();
        host_we_i    = 1'b0;
        next_cycle();
        model_mem[addr] = data;
    endtask

    // Latency is 1 or 2 cycles depending on engine contention
    task automatic host_read_check(input int addr);
        int waited;
        host_addr_i = `SPI_ADDR_W'(addr);
        host_re_i   = 1'b1;
        next_cycle();
        host_re_i   = 1'b0;
        waited      = 0;
        while (host_rvalid_o !== 1'b1) begin
            if (waited >= 1)
                abort_run($sformatf("host read of entry %0d never got host_rvalid_o", addr));
            next_cycle();
            waited++;
        end
        compare_value("host_rdata_o", 32'(model_mem[addr]), 32'(host_rdata_o));
        next_cycle();
    endtask

    // Host accesses to entries the engine does not touch
    task automatic host_traffic(input int first_free);
        int k;
        int addr;
        for (k = 0; k < 6; k++) begin
            repeat ($urandom_range(15, 0)) next_cycle();
            addr = $urandom_range(`SPI_BUF_DEPTH - 1, first_free);
            if ($urandom_range(1, 0) == 1)
                host_write(addr, 8'($urandom));
            else
                host_read_check(addr);
        end
    endtask

    task automatic wait_done(input int n_bytes, input logic [31:0] exp_stat);
        int cycles;
        cycles = 0;
        while (done_o !== 1'b1) begin
            if (cycles > n_bytes * BYTE_CYCLES + 20)
                abort_run($sformatf("done_o never pulsed for a %0d byte command", n_bytes));
            next_cycle();
            cycles++;
        end
        compare_value("cs_n_o", 32'd1, 32'(cs_n_o));
        compare_value("ctrl_rdata_o", exp_stat, ctrl_rdata_o);
        next_cycle();
        compare_value("done_o", 32'd0, 32'(done_o));   // One cycle strobe
    endtask

    //////////////////////////////
    // Command scenarios
    //////////////////////////////

    task automatic run_transfer();
        ctrl_cmd_t              cmd;
        int                     mode;
        int                     n_bytes;
        int                     base;
        int                     i;
        logic [`SPI_BYTE_W-1:0] exp_byte;
        logic [31:0]            exp_stat;
        cmd            = '0;
        cmd.send       = 1'b1;
        cmd.cs_en      = 1'b1;
        mode           = $urandom_range(5, 0);
        cmd.fill_ones  = (mode == 3 || mode == 5);
        cmd.fill_zeros = (mode == 4 || mode == 5);
        cmd.count_m1   = `SPI_ADDR_W'($urandom);
        n_bytes        = int'(cmd.count_m1) + 1;
        for (i = 0; i < n_bytes; i++)
            host_write(i, 8'($urandom));
        // Send cleared and completed bytes in bits 21..16
        exp_stat = (32'(cmd) & ~32'h1) | (32'(n_bytes) << 16);
        base     = mosi_seen_q.size();

        ctrl_wdata_i = cmd;
        ctrl_we_i    = 1'b1;
        next_cycle();
        ctrl_we_i    = 1'b0;
        compare_value("cs_n_o", 32'd0, 32'(cs_n_o));
        fork
            wait_done(n_bytes, exp_stat);
            begin
                if (n_bytes < `SPI_BUF_DEPTH)
                    host_traffic(n_bytes);
            end
        join

        compare_value("slave_byte_count", 32'(n_bytes), 32'(mosi_seen_q.size() - base));
        for (i = 0; i < n_bytes; i++) begin
            if (cmd.fill_ones)
                exp_byte = 8'hff;
            else if (cmd.fill_zeros)
                exp_byte = 8'h00;
            else
                exp_byte = model_mem[i];
            compare_value("mosi_o byte", 32'(exp_byte), 32'(mosi_seen_q[base + i]));
            model_mem[i] = miso_sent_q[base + i];   // Received byte lands in same entry
        end
        for (i = 0; i < `SPI_BUF_DEPTH; i++)
            host_read_check(i);
    endtask

    // Send without chip select enable stays idle
    task automatic idle_command_check();
        logic [31:0] word;
        int          k;
        word         = $urandom;
        word[0]      = 1'b1;
        word[1]      = 1'b0;
        ctrl_wdata_i = word;
        ctrl_we_i    = 1'b1;
        next_cycle();
        ctrl_we_i    = 1'b0;
        for (k = 0; k < IDLE_WINDOW; k++) begin
            compare_value("cs_n_o", 32'd1, 32'(cs_n_o));
            next_cycle();
        end
        compare_value("ctrl_rdata_o", word, ctrl_rdata_o);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int n;
        int a;
        void'($urandom(SEED));
        repeat (8) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        compare_value("cs_n_o", 32'd1, 32'(cs_n_o));
        compare_value("sclk_o", 32'd0, 32'(sclk_o));
        compare_value("mosi_o", 32'd0, 32'(mosi_o));
        compare_value("done_o", 32'd0, 32'(done_o));
        compare_value("host_rvalid_o", 32'd0, 32'(host_rvalid_o));

        for (a = 0; a < `SPI_BUF_DEPTH; a++)
            host_write(a, 8'($urandom));
        for (n = 0; n < NUM_CMDS; n++) begin
            if (n % 8 == 5)
                idle_command_check();
            else
                run_transfer();
        end
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(NUM_CMDS * `SPI_BUF_DEPTH * BYTE_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the command sequence finished");
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/spi_pkg.sv
hw/spi_buf_if.sv
hw/spi_byte_if.sv
hw/spi_shifter.sv
hw/spi_sequencer.sv
hw/spi_buf_arbiter.sv
hw/spi_master_top.sv
test/tb_spi_master.sv

// ==== Makefile ====
TOP := tb_spi_master

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
